//--- include/psx_defines.svh
`ifndef PSX_DEFINES_SVH
`define PSX_DEFINES_SVH

// link timing, all in clk cycles

// reset to first frame, kept short for simulation
`define PSX_BOOT_CYCLES 32'd200

// clk cycles per psx_clk half period
`define PSX_HALF_BIT 8'd4

`define PSX_ATT_SETUP 8'd8 // att low to first bit

// pad must pull ack low within this many cycles after a byte
`define PSX_ACK_TIMEOUT 8'd40

`define PSX_FRAME_GAP 8'd30 // att high between frames

// frame constants
`define PSX_CMD_START 8'h01
`define PSX_CMD_POLL 8'h42

// expected pad answers
`define PSX_ID_DIGITAL 8'h41
`define PSX_MARKER 8'h5A

`endif

//--- src/psx_pkg.sv
package psx_pkg;

    // poll sequencer states
    typedef enum logic [2:0] {
        st_boot,
        st_att_pulse,
        st_att_setup,
        st_xfer,
        st_await_ack,
        st_frame_end,
        st_gap
    } psx_state_e;

    // sequencer to byte transfer unit
    typedef struct packed {
        logic       start;   // one cycle, only while idle
        logic [7:0] tx_byte;
    } psx_xfer_req_t;

    // byte transfer unit back to sequencer
    typedef struct packed {
        logic       done;
        logic [7:0] rx_byte; // valid with done
    } psx_xfer_rsp_t;

    // frame result towards the report stage
    typedef struct packed {
        logic        frame_ok;
        logic        frame_err;
        logic [15:0] buttons; // low active, valid with frame_ok
    } psx_report_t;

endpackage

//--- src/psx_byte_xfer.sv
`timescale 1ns/10ps

`include "psx_defines.svh"

module psx_byte_xfer (
    input  logic                   clk,
    input  logic                   arst_n,
    input  psx_pkg::psx_xfer_req_t req,
    output psx_pkg::psx_xfer_rsp_t rsp,
    input  logic                   data,
    output logic                   psx_clk,
    output logic                   cmd
);

    localparam logic [7:0] half_last = `PSX_HALF_BIT - 8'd1;

    logic       busy;
    logic [7:0] half_cnt;
    logic [3:0] phase;    // even is psx_clk low, odd is high
    logic [7:0] tx_sr;
    logic [7:0] rx_sr;
    logic       half_end;
    logic       last_cycle;

    assign half_end = (half_cnt == half_last);
    assign last_cycle = busy && half_end && (phase == 4'd15);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            half_cnt <= '0;
            phase <= '0;
            psx_clk <= 1'b1;
            cmd <= 1'b1;
        end else if (!busy) begin
            if (req.start) begin
                busy <= 1'b1;
                half_cnt <= '0;
                phase <= '0;
                psx_clk <= 1'b0;
                cmd <= req.tx_byte[0]; // lsb goes first
            end
        end else if (half_end) begin
            half_cnt <= '0;
            phase <= phase + 4'd1;
            if (!phase[0]) begin
                psx_clk <= 1'b1;
            end else if (phase == 4'd15) begin
                busy <= 1'b0;
                cmd <= 1'b1; // back to idle level
            end else begin
                psx_clk <= 1'b0;
                cmd <= tx_sr[0];
            end
        end else begin
            half_cnt <= half_cnt + 8'd1;
        end
    end

    // shift registers for the byte in flight
    always_ff @(posedge clk) begin
        if (!busy && req.start) begin
            tx_sr <= {1'b1, req.tx_byte[7:1]};
        end else if (busy && half_end && phase[0] && phase != 4'd15) begin
            tx_sr <= {1'b1, tx_sr[7:1]};
        end

        // data sampled as psx_clk rises
        if (busy && half_end && !phase[0]) begin
            rx_sr <= {data, rx_sr[7:1]};
        end
    end

    assign rsp = '{done: last_cycle, rx_byte: rx_sr};

endmodule

//--- src/psx_poll_fsm.sv
`timescale 1ns/10ps

`include "psx_defines.svh"

module psx_poll_fsm (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   ack,
    output logic                   att,
    output psx_pkg::psx_xfer_req_t req,
    input  psx_pkg::psx_xfer_rsp_t rsp,
    output psx_pkg::psx_report_t   report
);

    localparam logic [31:0] boot_last = `PSX_BOOT_CYCLES - 32'd1;
    localparam logic [31:0] pulse_last = 32'(`PSX_HALF_BIT) - 32'd1;
    localparam logic [31:0] setup_last = 32'(`PSX_ATT_SETUP) - 32'd1;
    localparam logic [31:0] ack_last = 32'(`PSX_ACK_TIMEOUT) - 32'd1;
    localparam logic [31:0] gap_last = 32'(`PSX_FRAME_GAP) - 32'd1;

    psx_pkg::psx_state_e state;

    logic [31:0] wait_cnt;
    logic [2:0]  byte_idx;
    logic        pulse_done; // att pulse already sent for the coming frame
    logic        frame_bad;
    logic        start_q;
    logic        frame_ok_q;
    logic        frame_err_q;
    logic [7:0]  btn_lo;
    logic [7:0]  btn_hi;
    logic        check_fail;

    // command byte for each slot of the frame
    function automatic logic [7:0] cmd_byte(input logic [2:0] idx);
        case (idx)
            3'd0: cmd_byte = `PSX_CMD_START;
            3'd1: cmd_byte = `PSX_CMD_POLL;
            default: cmd_byte = 8'h00;
        endcase
    endfunction

    always_comb begin
        check_fail = 1'b0;
        if (byte_idx == 3'd1 && rsp.rx_byte != `PSX_ID_DIGITAL) begin
            check_fail = 1'b1;
        end
        if (byte_idx == 3'd2 && rsp.rx_byte != `PSX_MARKER) begin
            check_fail = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= psx_pkg::st_boot;
            wait_cnt <= '0;
            byte_idx <= '0;
            pulse_done <= 1'b0;
            frame_bad <= 1'b0;
            start_q <= 1'b0;
            att <= 1'b1;
            frame_ok_q <= 1'b0;
            frame_err_q <= 1'b0;
        end else begin
            start_q <= 1'b0;
            frame_ok_q <= 1'b0;
            frame_err_q <= 1'b0;
            wait_cnt <= wait_cnt + 32'd1;
            case (state)
                psx_pkg::st_boot: begin
                    if (wait_cnt == boot_last) begin
                        att <= 1'b0;
                        wait_cnt <= '0;
                        state <= psx_pkg::st_att_pulse;
                    end
                end
                psx_pkg::st_att_pulse: begin
                    if (wait_cnt == pulse_last) begin
                        att <= 1'b1;
                        pulse_done <= 1'b1;
                        wait_cnt <= '0;
                        state <= psx_pkg::st_gap;
                    end
                end
                psx_pkg::st_gap: begin
                    if (wait_cnt == gap_last) begin
                        att <= 1'b0; // either the pulse or the frame itself
                        wait_cnt <= '0;
                        pulse_done <= 1'b0;
                        state <= pulse_done ? psx_pkg::st_att_setup : psx_pkg::st_att_pulse;
                    end
                end
                psx_pkg::st_att_setup: begin
                    if (wait_cnt == setup_last) begin
                        byte_idx <= '0;
                        start_q <= 1'b1;
                        state <= psx_pkg::st_xfer;
                    end
                end
                psx_pkg::st_xfer: begin
                    if (rsp.done) begin
                        wait_cnt <= '0;
                        if (check_fail) begin
                            frame_bad <= 1'b1;
                            state <= psx_pkg::st_frame_end;
                        end else if (byte_idx == 3'd4) begin
                            state <= psx_pkg::st_frame_end; // no ack after last byte
                        end else begin
                            state <= psx_pkg::st_await_ack;
                        end
                    end
                end
                psx_pkg::st_await_ack: begin
                    if (!ack) begin
                        byte_idx <= byte_idx + 3'd1;
                        start_q <= 1'b1;
                        state <= psx_pkg::st_xfer;
                    end else if (wait_cnt == ack_last) begin
                        frame_bad <= 1'b1;
                        state <= psx_pkg::st_frame_end;
                    end
                end
                psx_pkg::st_frame_end: begin
                    att <= 1'b1;
                    frame_ok_q <= !frame_bad;
                    frame_err_q <= frame_bad;
                    frame_bad <= 1'b0;
                    wait_cnt <= '0;
                    state <= psx_pkg::st_gap;
                end
                default: begin
                    att <= 1'b1;
                    wait_cnt <= '0;
                    state <= psx_pkg::st_gap;
                end
            endcase
        end
    end

    // button bytes, low byte arrives first
    always_ff @(posedge clk) begin
        if (state == psx_pkg::st_xfer && rsp.done) begin
            if (byte_idx == 3'd3) begin
                btn_lo <= rsp.rx_byte;
            end
            if (byte_idx == 3'd4) begin
                btn_hi <= rsp.rx_byte;
            end
        end
    end

    assign req = '{start: start_q, tx_byte: cmd_byte(byte_idx)};

    assign report = '{
        frame_ok: frame_ok_q,
        frame_err: frame_err_q,
        buttons: {btn_hi, btn_lo}
    };

endmodule

//--- src/psx_pad_report.sv
`timescale 1ns/10ps

module psx_pad_report (
    input  logic                 clk,
    input  logic                 arst_n,
    input  psx_pkg::psx_report_t report,
    output logic [15:0]          buttons,
    output logic [15:0]          pressed,
    output logic                 report_valid,
    output logic                 poll_error
);

    logic [15:0] new_press;

    // low active, so a press is a 1 to 0 step
    assign new_press = buttons & ~report.buttons;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            buttons <= 16'hFFFF; // nothing pressed
            pressed <= '0;
        end else if (report.frame_ok) begin
            buttons <= report.buttons;
            pressed <= new_press;
        end
    end

    // status pulses, one cycle behind the sequencer
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            report_valid <= 1'b0;
            poll_error <= 1'b0;
        end else begin
            report_valid <= report.frame_ok;
            poll_error <= report.frame_err;
        end
    end

endmodule

//--- src/psx_pad_host.sv
`timescale 1ns/10ps

module psx_pad_host (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        data,
    input  logic        ack,
    output logic        psx_clk,
    output logic        cmd,
    output logic        att,
    output logic [15:0] buttons,
    output logic [15:0] pressed,
    output logic        report_valid,
    output logic        poll_error
);

    psx_pkg::psx_xfer_req_t xfer_req;
    psx_pkg::psx_xfer_rsp_t xfer_rsp;
    psx_pkg::psx_report_t   frame_report;

    psx_poll_fsm poll_fsm_i (
        .clk    (clk),
        .arst_n (arst_n),
        .ack    (ack),
        .att    (att),
        .req    (xfer_req),
        .rsp    (xfer_rsp),
        .report (frame_report)
    );

    // owns psx_clk and cmd
    psx_byte_xfer byte_xfer_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .req     (xfer_req),
        .rsp     (xfer_rsp),
        .data    (data),
        .psx_clk (psx_clk),
        .cmd     (cmd)
    );

    psx_pad_report pad_report_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .report       (frame_report),
        .buttons      (buttons),
        .pressed      (pressed),
        .report_valid (report_valid),
        .poll_error   (poll_error)
    );

endmodule

//--- tests/psx_pad_properties.sv
`timescale 1ns/10ps

module psx_pad_properties (
    input logic clk,
    input logic arst_n,
    input logic psx_clk,
    input logic cmd,
    input logic att,
    input logic report_valid,
    input logic poll_error
);

    // data is sampled on the rising edge, so cmd must hold there
    assert property (@(posedge clk) disable iff (!arst_n)
        $rose(psx_clk) |-> $stable(cmd))
        else $error("cmd changed on a rising psx_clk edge");

    // while psx_clk is high cmd may only return to its idle level
    assert property (@(posedge clk) disable iff (!arst_n)
        (!$stable(cmd) && psx_clk) |-> cmd)
        else $error("cmd changed to low while psx_clk was high");

    assert property (@(posedge clk) disable iff (!arst_n)
        !$stable(psx_clk) |-> !att)
        else $error("psx_clk toggled while att was high");

    assert property (@(posedge clk) disable iff (!arst_n)
        !(report_valid && poll_error))
        else $error("report_valid and poll_error high together");

endmodule

bind psx_pad_host psx_pad_properties props_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .psx_clk      (psx_clk),
    .cmd          (cmd),
    .att          (att),
    .report_valid (report_valid),
    .poll_error   (poll_error)
);

//--- tests/psx_pad_checker.sv
`timescale 1ns/10ps

module psx_pad_checker (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        psx_clk,
    input  logic        cmd,
    input  logic        att,
    input  logic [15:0] buttons,
    input  logic [15:0] pressed,
    input  logic        report_valid,
    input  logic        poll_error,
    input  logic        exp_valid,   // pad model starts a frame
    input  logic        exp_err,
    input  logic [15:0] exp_buttons,
    output int          error_count,
    output int          frames_done,
    output int          good_frames,
    output int          bad_frames
);

    logic [16:0] exp_q[$];  // {err, word}
    logic [16:0] exp_item;
    logic [15:0] prev_good;
    logic [15:0] exp_press;
    logic [7:0]  cmd_sr;
    logic [7:0]  cmd_exp;
    logic        psx_clk_q;
    int          bit_cnt;
    int          byte_cnt;

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            error_count <= 0;
            frames_done <= 0;
            good_frames <= 0;
            bad_frames <= 0;
            prev_good <= 16'hFFFF;
            psx_clk_q <= 1'b1;
            bit_cnt <= 0;
            byte_cnt <= 0;
            exp_q.delete();
        end else begin
            psx_clk_q <= psx_clk;
            if (exp_valid) begin
                exp_q.push_back({exp_err, exp_buttons});
            end

            // rebuild command bytes, lsb first
            if (att) begin
                bit_cnt <= 0;
                byte_cnt <= 0;
            end else if (psx_clk && !psx_clk_q) begin
                cmd_sr = {cmd, cmd_sr[7:1]};
                if (bit_cnt == 7) begin
                    bit_cnt <= 0;
                    byte_cnt <= byte_cnt + 1;
                    cmd_exp = (byte_cnt == 0) ? 8'h01 : (byte_cnt == 1) ? 8'h42 : 8'h00;
                    if (byte_cnt > 4) begin
                        $display("more than five bytes sent in one frame at %0t", $time);
                        error_count <= error_count + 1;
                    end else if (cmd_sr != cmd_exp) begin
                        $display("FAILED at %0t: cmd byte %0d got %h expected %h",
                                 $time, byte_cnt, cmd_sr, cmd_exp);
                        error_count <= error_count + 1;
                    end
                end else begin
                    bit_cnt <= bit_cnt + 1;
                end
            end

            if (report_valid || poll_error) begin
                frames_done <= frames_done + 1;
                if (exp_q.size() == 0) begin
                    $display("report pulse at %0t with no frame pending", $time);
                    error_count <= error_count + 1;
                end else begin
                    exp_item = exp_q.pop_front();
                    if (!att) begin
                        $display("att still low at end of frame at %0t", $time);
                        error_count <= error_count + 1;
                    end
                    if (report_valid) begin
                        good_frames <= good_frames + 1;
                        exp_press = prev_good & ~exp_item[15:0];
                        if (exp_item[16]) begin
                            $display("report_valid at %0t for a frame that should fail",
                                     $time);
                            error_count <= error_count + 1;
                        end else if (buttons != exp_item[15:0]) begin
                            $display("FAILED at %0t: buttons got %h expected %h",
                                     $time, buttons, exp_item[15:0]);
                            error_count <= error_count + 1;
                        end else if (pressed != exp_press) begin
                            $display("FAILED at %0t: pressed got %h expected %h",
                                     $time, pressed, exp_press);
                            error_count <= error_count + 1;
                        end
                        prev_good <= exp_item[15:0];
                    end else begin
                        bad_frames <= bad_frames + 1;
                        if (!exp_item[16]) begin
                            $display("poll_error at %0t for a frame that should pass", $time);
                            error_count <= error_count + 1;
                        end else if (buttons != prev_good) begin
                            $display("FAILED at %0t: buttons got %h expected %h",
                                     $time, buttons, prev_good);
                            error_count <= error_count + 1;
                        end
                    end
                end
            end
        end
    end

endmodule

//--- tests/psx_pad_host_tb.sv
`timescale 1ns/10ps

`include "psx_defines.svh"

module psx_pad_host_tb;

    localparam int num_frames = 60;
    // att pulse, two gaps, setup, five bytes and four full ack waits
    localparam int frame_worst = `PSX_HALF_BIT + 2 * `PSX_FRAME_GAP + `PSX_ATT_SETUP
                               + 5 * (16 * `PSX_HALF_BIT + 2) + 4 * (`PSX_ACK_TIMEOUT + 2) + 8;
    localparam int cycle_limit = num_frames * frame_worst + `PSX_BOOT_CYCLES + 100;

    logic        clk;
    logic        arst_n;
    logic        data;
    logic        ack;
    logic        psx_clk;
    logic        cmd;
    logic        att;
    logic [15:0] buttons;
    logic [15:0] pressed;
    logic        report_valid;
    logic        poll_error;
    logic        exp_valid;
    logic        exp_err;
    logic [15:0] exp_buttons;
    int          error_count;
    int          frames_done;
    int          good_frames;
    int          bad_frames;
    int          cycles;
    int          misses;

    // pad model state
    logic [31:0] rng;
    logic [15:0] word;
    logic [7:0]  tx_sr;
    logic        psx_clk_q;
    logic        in_frame;
    int          fault;    // 0 good, 1 withheld ack, 2 bad id
    int          drop_idx;
    int          bit_cnt;
    int          byte_cnt;
    int          ack_wait;
    int          ack_low;

    psx_pad_host psx_pad_host_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .data         (data),
        .ack          (ack),
        .psx_clk      (psx_clk),
        .cmd          (cmd),
        .att          (att),
        .buttons      (buttons),
        .pressed      (pressed),
        .report_valid (report_valid),
        .poll_error   (poll_error)
    );

    psx_pad_checker checker_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .psx_clk      (psx_clk),
        .cmd          (cmd),
        .att          (att),
        .buttons      (buttons),
        .pressed      (pressed),
        .report_valid (report_valid),
        .poll_error   (poll_error),
        .exp_valid    (exp_valid),
        .exp_err      (exp_err),
        .exp_buttons  (exp_buttons),
        .error_count  (error_count),
        .frames_done  (frames_done),
        .good_frames  (good_frames),
        .bad_frames   (bad_frames)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // what the pad answers in each byte slot
    function automatic logic [7:0] pad_answer(input int idx, input int kind,
                                              input logic [15:0] w);
        case (idx)
            0: return 8'hFF;
            1: return (kind == 2) ? 8'h73 : 8'h41;
            2: return 8'h5A;
            3: return w[7:0];
            default: return w[15:8];
        endcase
    endfunction

    always #20 clk = ~clk;

    always @(posedge clk) cycles <= cycles + 1;

    always @(negedge clk) begin
        exp_valid = 1'b0;
        if (arst_n && att) begin
            in_frame = 1'b0;
            bit_cnt = 0;
            byte_cnt = 0;
            ack_wait = 0;
            ack_low = 0;
            data = 1'b1;
            ack = 1'b1;
        end else if (arst_n) begin
            if (!psx_clk && psx_clk_q) begin
                if (!in_frame) begin
                    in_frame = 1'b1;
                    rng = xorshift(rng);
                    word = rng[15:0];
                    fault = rng[23:16] % 3;
                    drop_idx = rng[31:24] % 4;
                    exp_valid = 1'b1;
                    exp_err = (fault != 0);
                    exp_buttons = word;
                end
                if (bit_cnt == 0) begin
                    tx_sr = pad_answer(byte_cnt, fault, word);
                end
                data = tx_sr[0];
                tx_sr = tx_sr >> 1;
            end else if (psx_clk && !psx_clk_q) begin
                bit_cnt = bit_cnt + 1;
                if (bit_cnt == 8) begin
                    bit_cnt = 0;
                    if (byte_cnt < 4 && !(fault == 1 && byte_cnt == drop_idx)) begin
                        rng = xorshift(rng);
                        // byte ends half a bit after its last rising edge
                        ack_wait = `PSX_HALF_BIT + 3 + rng % 18;
                    end
                    byte_cnt = byte_cnt + 1;
                end
            end
            if (ack_wait > 0) begin
                ack_wait = ack_wait - 1;
                if (ack_wait == 0) begin
                    ack_low = 2;
                end
            end
            if (ack_low > 0) begin
                ack = 1'b0;
                ack_low = ack_low - 1;
            end else begin
                ack = 1'b1;
            end
        end
        psx_clk_q = psx_clk;
    end

    initial begin
        clk = 1'b0;
        arst_n = 1'b0;
        data = 1'b1;
        ack = 1'b1;
        exp_valid = 1'b0;
        exp_err = 1'b0;
        exp_buttons = 16'hFFFF;
        cycles = 0;
        misses = 0;
        rng = 32'hc9e34a01;
        psx_clk_q = 1'b1;
        in_frame = 1'b0;
        fault = 0;
        bit_cnt = 0;
        byte_cnt = 0;
        ack_wait = 0;
        ack_low = 0;
        repeat (4) @(negedge clk);
        arst_n = 1'b1;

        while (frames_done < num_frames && cycles < cycle_limit) begin
            @(posedge clk);
        end
        @(negedge clk);
        if (frames_done < num_frames) begin
            $display("timeout after %0d cycles with %0d of %0d frames done",
                     cycles, frames_done, num_frames);
            misses = misses + 1;
        end
        if (good_frames == 0 || bad_frames == 0) begin
            $display("run did not produce both good and failed frames");
            misses = misses + 1;
        end
        $display("errors %0d, other failures %0d, frames %0d, good %0d, failed %0d",
                 error_count, misses, frames_done, good_frames, bad_frames);
        if (error_count == 0 && misses == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+include
src/psx_pkg.sv
src/psx_byte_xfer.sv
src/psx_poll_fsm.sv
src/psx_pad_report.sv
src/psx_pad_host.sv
tests/psx_pad_properties.sv
tests/psx_pad_checker.sv
tests/psx_pad_host_tb.sv

//--- run.sh
#!/bin/sh
# compile and run with Verilator, result taken from the log
verilator --binary --timing --assert -f sources.f --top-module psx_pad_host_tb -o psx_sim \
    && ./obj_dir/psx_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
